/* dv/railMapTb.sv */
/*
 Testbench for the rail-map colour stage. The model knows only stations
 1 to 4 and route segments 0 and 3, so all stimulus stays inside them.
*/
`timescale 1ns/1ns

module railMapTb;

    typedef struct packed {
        railMapPkg::pixelT     pixel;
        railMapPkg::layerCodeT pageLayer;
        railMapPkg::layerCodeT mapLayer;
        logic                  mapPage;
        logic                  mouseHit;
        railMapPkg::pixelT     cursor;
        railMapPkg::sceneT     scene;
    } stimT;

    // Reset, start page, mouse, markers, routes, hover, random, flush
    localparam int stimCycles    = 3 + 24 + 16 + 55 + 48 + 52 + 400 + 4;
    localparam int timeoutCycles = 2 * stimCycles;

    localparam int stnX [4] = '{569, 563, 547, 465};    // Stations 1 to 4
    localparam int stnY [4] = '{97, 125, 160, 186};

    // Corners, centres and near misses of segments 0 and 3
    localparam int routeX [10] = '{563, 569, 566, 562, 570, 465, 478, 470, 464, 470};
    localparam int routeY [10] = '{97, 125, 110, 110, 110, 188, 199, 193, 193, 200};

    logic                  Clk;
    logic                  rstN;
    stimT                  stim;
    railMapPkg::rgbT       rgb;
    railMapPkg::stationIdT hoverStation;

    logic [31:0]           lcgState   = 32'd23949;
    int                    cycleCount = 0;
    string                 testName   = "reset";
    railMapPkg::rgbT       expRgb1    = '0;
    railMapPkg::rgbT       expRgb2    = '0;
    railMapPkg::stationIdT expHover   = '0;
    string                 rgbName1   = "reset";
    string                 rgbName2   = "reset";
    string                 hoverName  = "reset";

    tbClockGen clockGen (.Clk);

    railMapColorMapper dut (
        .Clk, .rstN,
        .pixel(stim.pixel), .pageLayer(stim.pageLayer), .mapLayer(stim.mapLayer),
        .mapPage(stim.mapPage), .mouseHit(stim.mouseHit), .cursor(stim.cursor),
        .scene(stim.scene), .rgb, .hoverStation
    );

    // ------------------------------------------------------------------
    // Random numbers and the reference model
    // ------------------------------------------------------------------
    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[31:16]};
    endfunction

    function automatic int randRange(int lo, int hi);
        return lo + int'(nextRand() % unsigned'(hi - lo + 1));
    endfunction

    // Ids outside 1..4 never match
    function automatic logic nearStation(railMapPkg::pixelT p, int id);
        int dx;
        int dy;

        if (id < 1 || id > 4)
            return 1'b0;
        dx = int'(p.x) - stnX[id-1];
        dy = int'(p.y) - stnY[id-1];
        return (dx >= -1) && (dx <= 1) && (dy >= -1) && (dy <= 1);
    endfunction

    function automatic logic inRect(railMapPkg::pixelT p, int xLo, int xHi, int yLo, int yHi);
        return (int'(p.x) >= xLo) && (int'(p.x) <= xHi) &&
               (int'(p.y) >= yLo) && (int'(p.y) <= yHi);
    endfunction

    function automatic railMapPkg::rgbT makeRgb(int r, int g, int b);
        return '{railMapPkg::channelT'(r), railMapPkg::channelT'(g),
                 railMapPkg::channelT'(b)};
    endfunction

    function automatic railMapPkg::rgbT expectColor(stimT s);
        logic routeHit;

        routeHit = (s.scene.routeMask[0] && inRect(s.pixel, 563, 569, 97, 125)) ||
                   (s.scene.routeMask[3] && inRect(s.pixel, 465, 478, 188, 199));
        if (s.mouseHit)
            return makeRgb(255, 215, 0);
        if (!s.mapPage)
        begin
            case (s.pageLayer)
                2'd0:    return makeRgb(109, 179, 89);
                2'd1:    return makeRgb(247, 248, 250);
                2'd2:    return makeRgb(217, 245, 248);
                default: return makeRgb(27, 55, 73);
            endcase
        end
        case (s.mapLayer)
            2'd0:
            begin
                if (nearStation(s.pixel, int'(s.scene.endStation)))
                    return makeRgb(0, 255, 255);    // End wins over start
                if (nearStation(s.pixel, int'(s.scene.beginStation)))
                    return makeRgb(255, 0, 0);
                return makeRgb(0, 0, 0);
            end
            2'd1:    return makeRgb(255, 255, 255);
            2'd2:    return routeHit ? makeRgb(0, 0, 255) : makeRgb(85, 109, 75);
            default: return makeRgb(255, 195, 195);
        endcase
    endfunction

    function automatic railMapPkg::stationIdT expectHover(railMapPkg::pixelT c);
        int best;

        best = 0;
        for (int id = 1; id <= 4; id++)
        begin
            if (nearStation(c, id))
                best = id;                      // Highest id wins
        end
        return railMapPkg::stationIdT'(best);
    endfunction

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic stimT idleStim();
        stimT s;

        s = '0;
        s.cursor = '{10'd10, 10'd10};          // Far from every station
        return s;
    endfunction

    // Half the time near a known station, else an area with no other station hits
    function automatic railMapPkg::pixelT randPoint(logic forCursor);
        railMapPkg::pixelT p;
        int                id;

        id = randRange(0, 3);
        if (randRange(0, 1) == 0)
        begin
            p.x = railMapPkg::coordT'(stnX[id] + randRange(-2, 2));
            p.y = railMapPkg::coordT'(stnY[id] + randRange(-2, 2));
        end
        else if (forCursor)
        begin
            p.x = railMapPkg::coordT'(randRange(0, 400));
            p.y = railMapPkg::coordT'(randRange(0, 80));
        end
        else
        begin
            p.x = railMapPkg::coordT'(randRange(460, 575));
            p.y = railMapPkg::coordT'(randRange(90, 205));
        end
        return p;
    endfunction

    function automatic stimT randomStim();
        stimT s;

        s.pixel              = randPoint(1'b0);
        s.cursor             = randPoint(1'b1);
        s.pageLayer          = railMapPkg::layerCodeT'(randRange(0, 3));
        s.mapLayer           = railMapPkg::layerCodeT'(randRange(0, 3));
        s.mapPage            = (randRange(0, 3) != 0);
        s.mouseHit           = (randRange(0, 7) == 0);
        s.scene.beginStation = railMapPkg::stationIdT'(randRange(0, 4));
        s.scene.endStation   = railMapPkg::stationIdT'(randRange(0, 4));
        s.scene.routeMask    = '0;               // Only segments 0 and 3
        s.scene.routeMask[0] = (randRange(0, 1) == 1);
        s.scene.routeMask[3] = (randRange(0, 1) == 1);
        return s;
    endfunction

    task automatic drivePixel(stimT s);
        stim = s;
        @(negedge Clk);
    endtask

    task automatic driveAt(stimT base, int x, int y);
        base.pixel = '{railMapPkg::coordT'(x), railMapPkg::coordT'(y)};
        drivePixel(base);
    endtask

    // Steps pixel or cursor over a 5x5 square
    task automatic sweepSquare(stimT base, int cx, int cy, logic moveCursor);
        stimT s;

        s = base;
        for (int dy = -2; dy <= 2; dy++)
        begin
            for (int dx = -2; dx <= 2; dx++)
            begin
                if (moveCursor)
                    s.cursor = '{railMapPkg::coordT'(cx + dx), railMapPkg::coordT'(cy + dy)};
                else
                    s.pixel = '{railMapPkg::coordT'(cx + dx), railMapPkg::coordT'(cy + dy)};
                drivePixel(s);
            end
        end
    endtask

    task automatic reportMismatch(string name, string what, logic [23:0] expected,
                                  logic [23:0] actual);
        $display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first mismatch");
    endtask

    // ------------------------------------------------------------------
    // Expected pipeline and checks
    // ------------------------------------------------------------------
    always @(posedge Clk)
    begin
        if (!rstN)
        begin
            expRgb1   = '0;
            expRgb2   = '0;
            expHover  = '0;
            rgbName1  = "reset";
            rgbName2  = "reset";
            hoverName = "reset";
        end
        else
        begin
            expRgb2   = expRgb1;                // rgb lags two clocks
            rgbName2  = rgbName1;
            expRgb1   = expectColor(stim);
            rgbName1  = testName;
            expHover  = expectHover(stim.cursor);
            hoverName = testName;
        end
    end

    // Registered outputs are settled at the falling edge
    rgbCheck: assert property (@(negedge Clk) rgb === expRgb2)
        else reportMismatch(rgbName2, "rgb", expRgb2, rgb);
    hoverCheck: assert property (@(negedge Clk) hoverStation === expHover)
        else reportMismatch(hoverName, "hoverStation", 24'(expHover), 24'(hoverStation));

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("RESULT: FAIL");
            $display("Timeout, run did not end within %0d cycles", timeoutCycles);
            $fatal(1, "Timeout");
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        stimT s;

        rstN = 1'b0;
        stim = idleStim();
        stim.cursor = '{10'd569, 10'd97};      // Cursor on station 1 while hover is held in reset
        repeat (3) @(negedge Clk);
        rstN = 1'b1;
        resetRgb: assert (rgb == '0)
            else reportMismatch("reset", "rgb", 24'd0, rgb);
        resetHover: assert (hoverStation == '0)
            else reportMismatch("reset", "hoverStation", 24'd0, 24'(hoverStation));

        testName = "startPage";
        for (int i = 0; i < 24; i++)
        begin
            s = randomStim();
            s.mapPage  = 1'b0;
            s.mouseHit = 1'b0;
            if (i < 4)
                s.pageLayer = railMapPkg::layerCodeT'(i);   // Every class at least once
            drivePixel(s);
        end

        testName = "mouse";
        for (int i = 0; i < 16; i++)
        begin
            s = randomStim();
            s.mouseHit = 1'b1;
            s.mapPage  = i[0];
            drivePixel(s);
        end

        testName = "markers";
        s = idleStim();
        s.mapPage            = 1'b1;
        s.scene.beginStation = 4'd2;
        s.scene.endStation   = 4'd4;
        sweepSquare(s, 563, 125, 1'b0);
        sweepSquare(s, 465, 186, 1'b0);
        s.scene.endStation = 4'd2;              // Both markers on one station
        driveAt(s, 563, 125);

        testName = "noStation";
        s.scene.beginStation = 4'd0;
        s.scene.endStation   = 4'd0;
        driveAt(s, 563, 125);
        driveAt(s, 465, 186);
        driveAt(s, 0, 0);
        driveAt(s, 1, 1);

        testName = "routes";
        s = idleStim();
        s.mapPage  = 1'b1;
        s.mapLayer = 2'd2;
        for (int m = 0; m < 4; m++)
        begin
            s.scene.routeMask    = '0;
            s.scene.routeMask[0] = m[0];
            s.scene.routeMask[3] = m[1];
            for (int k = 0; k < 10; k++)
                driveAt(s, routeX[k], routeY[k]);
        end

        testName = "plainLayers";
        for (int i = 0; i < 8; i++)
        begin
            s.mapLayer = (i < 4) ? 2'd1 : 2'd3;
            s.pixel    = randPoint(1'b0);
            drivePixel(s);
        end

        testName = "hover";
        s = idleStim();
        sweepSquare(s, 569, 97, 1'b1);
        sweepSquare(s, 547, 160, 1'b1);
        s.cursor = '{10'd639, 10'd479};
        drivePixel(s);
        s.cursor = '{10'd10, 10'd10};
        drivePixel(s);

        testName = "randomStream";
        for (int i = 0; i < 400; i++)
            drivePixel(randomStim());

        testName = "flush";
        stim = idleStim();
        repeat (4) @(negedge Clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* dv/tbClockGen.sv */
/*
 Free-running testbench clock with a 4 ns period, starting low.
*/
`timescale 1ns/1ns

module tbClockGen
(
    output logic Clk
);

    initial
    begin
        Clk = 1'b0;
        forever
        begin
            #2 Clk = ~Clk;    // Half period
        end
    end

endmodule

/* list.f */
+incdir+source
source/railMapPkg.sv
source/stationLocator.sv
source/markerRenderer.sv
source/routeOverlay.sv
source/colorPriority.sv
source/railMapColorMapper.sv
dv/tbClockGen.sv
dv/railMapTb.sv

/* run.sh */
#!/bin/sh
# Build the rail-map testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module railMapTb -o railMapSim

output=$(./obj_dir/railMapSim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

/* source/colorPriority.sv */
/*
 Two-stage colour pipeline. rgb trails the classification inputs by two
 clocks and reads 0 until the first post-reset pixel reaches stage 2.
*/
`timescale 1ns/1ns

module colorPriority
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  railMapPkg::layerHitsT hits,
    input  railMapPkg::layerCodeT pageLayer,
    input  railMapPkg::layerCodeT mapLayer,
    input  logic                  mapPage,
    input  logic                  mouseHit,
    output railMapPkg::rgbT       rgb
);

    // ------------------------------------------------------------------
    // Palette
    // ------------------------------------------------------------------
    localparam railMapPkg::rgbT goldColor  = '{8'd255, 8'd215, 8'd0};   // Mouse cursor
    localparam railMapPkg::rgbT blackColor = '{8'd0,   8'd0,   8'd0};
    localparam railMapPkg::rgbT redColor   = '{8'd255, 8'd0,   8'd0};   // Start station
    localparam railMapPkg::rgbT cyanColor  = '{8'd0,   8'd255, 8'd255}; // End station
    localparam railMapPkg::rgbT whiteColor = '{8'd255, 8'd255, 8'd255};
    localparam railMapPkg::rgbT landColor  = '{8'd85,  8'd109, 8'd75};
    localparam railMapPkg::rgbT blueColor  = '{8'd0,   8'd0,   8'd255}; // Highlighted route
    localparam railMapPkg::rgbT pinkColor  = '{8'd255, 8'd195, 8'd195}; // Info panel

    // Start page colours by pageLayer
    localparam railMapPkg::rgbT pagePalette [4] = '{
        '{8'd109, 8'd179, 8'd89},
        '{8'd247, 8'd248, 8'd250},
        '{8'd217, 8'd245, 8'd248},
        '{8'd27,  8'd55,  8'd73}
    };

    logic                  stage1Valid;     // Low until a real pixel is in stage 1
    railMapPkg::layerHitsT hitsQ;
    railMapPkg::layerCodeT pageLayerQ;
    railMapPkg::layerCodeT mapLayerQ;
    logic                  mapPageQ;
    logic                  mouseHitQ;
    railMapPkg::rgbT       colorNext;

    // ------------------------------------------------------------------
    // Stage 1
    // ------------------------------------------------------------------
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            stage1Valid <= 1'b0;
        else
            stage1Valid <= 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        hitsQ      <= hits;
        pageLayerQ <= pageLayer;
        mapLayerQ  <= mapLayer;
        mapPageQ   <= mapPage;
        mouseHitQ  <= mouseHit;
    end

    // ------------------------------------------------------------------
    // Stage 2
    // ------------------------------------------------------------------
    always_comb
    begin
        if (mouseHitQ)
            colorNext = goldColor;
        else if (!mapPageQ)
            colorNext = pagePalette[pageLayerQ];
        else
        begin
            case (mapLayerQ)
                2'd0:
                begin
                    colorNext = blackColor;
                    if (hitsQ.startHit)
                        colorNext = redColor;
                    if (hitsQ.endHit)
                        colorNext = cyanColor;     // End drawn over start
                end
                2'd1:    colorNext = whiteColor;
                2'd2:    colorNext = hitsQ.routeHit ? blueColor : landColor;
                default: colorNext = pinkColor;
            endcase
        end
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            rgb <= '0;
        else
            rgb <= stage1Valid ? colorNext : '0;
    end

endmodule

/* source/markerRenderer.sv */
/*
 Flags pixels inside the start or end station marker. Purely
 combinational. An id of 0 never draws a marker.
*/
`timescale 1ns/1ns
`include "rail_map_defines.svh"

module markerRenderer
(
    input  railMapPkg::pixelT pixel,
    input  railMapPkg::sceneT scene,
    output logic              startHit,
    output logic              endHit
);

    railMapPkg::pixelT beginCenter;
    railMapPkg::pixelT endCenter;

    // True when p lies in the square marker around c
    function automatic logic nearCenter(railMapPkg::pixelT p, railMapPkg::pixelT c);
        logic inX;
        logic inY;

        inX = (int'(p.x) >= int'(c.x) - `RM_MARKER_RADIUS) &&
              (int'(p.x) <= int'(c.x) + `RM_MARKER_RADIUS);
        inY = (int'(p.y) >= int'(c.y) - `RM_MARKER_RADIUS) &&
              (int'(p.y) <= int'(c.y) + `RM_MARKER_RADIUS);
        return inX && inY;
    endfunction

    // ------------------------------------------------------------------
    // Centre lookup
    // ------------------------------------------------------------------
    assign beginCenter = railMapPkg::stationCenter(scene.beginStation);
    assign endCenter   = railMapPkg::stationCenter(scene.endStation);

    // ------------------------------------------------------------------
    // Hit tests
    // ------------------------------------------------------------------
    // Id 0 maps to (0,0) and must not paint the corner
    assign startHit = (scene.beginStation != '0) && nearCenter(pixel, beginCenter);
    assign endHit   = (scene.endStation != '0) && nearCenter(pixel, endCenter);

endmodule

/* source/railMapColorMapper.sv */
/*
 Pixel colour stage of the rail map. rgb is valid two clocks after its
 inputs are sampled; hoverStation one clock after cursor.
*/
`timescale 1ns/1ns

module railMapColorMapper
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  railMapPkg::pixelT     pixel,
    input  railMapPkg::layerCodeT pageLayer,
    input  railMapPkg::layerCodeT mapLayer,
    input  logic                  mapPage,
    input  logic                  mouseHit,
    input  railMapPkg::pixelT     cursor,
    input  railMapPkg::sceneT     scene,
    output railMapPkg::rgbT       rgb,
    output railMapPkg::stationIdT hoverStation
);

    logic                  startHit;
    logic                  endHit;
    logic                  routeHit;
    railMapPkg::layerHitsT hits;

    stationLocator uLocator (.Clk, .rstN, .cursor, .hoverStation);

    markerRenderer uMarker (.pixel, .scene, .startHit, .endHit);

    routeOverlay uRoute (.pixel, .routeMask(scene.routeMask), .routeHit);

    assign hits = '{startHit, endHit, routeHit};

    colorPriority uPriority (
        .Clk, .rstN, .hits, .pageLayer, .mapLayer, .mapPage, .mouseHit, .rgb
    );

endmodule

/* source/railMapPkg.sv */
/*
 Shared types and the station centre table. Ids above 12 and id 0
 return (0,0), so callers must qualify the id themselves.
*/
`include "rail_map_defines.svh"

package railMapPkg;

    typedef logic [`RM_COORD_W-1:0]      coordT;
    typedef logic [`RM_CHANNEL_W-1:0]    channelT;
    typedef logic [`RM_STATION_ID_W-1:0] stationIdT;   // 0 means none
    typedef logic [`RM_NUM_SEGMENTS-1:0] routeMaskT;
    typedef logic [1:0]                  layerCodeT;   // Background class from sprite logic

    typedef struct packed {
        coordT x;
        coordT y;
    } pixelT;

    typedef struct packed {
        channelT red;
        channelT green;
        channelT blue;
    } rgbT;

    typedef struct packed {
        stationIdT beginStation;
        stationIdT endStation;
        routeMaskT routeMask;
    } sceneT;

    typedef struct packed {
        logic startHit;
        logic endHit;
        logic routeHit;
    } layerHitsT;

    // Centre pixel of each station on the map image
    function automatic pixelT stationCenter(stationIdT id);
        case (id)
            4'd1:    return '{10'd569, 10'd97};
            4'd2:    return '{10'd563, 10'd125};
            4'd3:    return '{10'd547, 10'd160};
            4'd4:    return '{10'd465, 10'd186};
            4'd5:    return '{10'd478, 10'd199};
            4'd6:    return '{10'd489, 10'd229};
            4'd7:    return '{10'd527, 10'd235};
            4'd8:    return '{10'd530, 10'd301};
            4'd9:    return '{10'd520, 10'd311};
            4'd10:   return '{10'd537, 10'd317};
            4'd11:   return '{10'd511, 10'd375};
            4'd12:   return '{10'd494, 10'd388};
            default: return '{10'd0, 10'd0};     // No station
        endcase
    endfunction

endpackage

/* source/rail_map_defines.svh */
/*
 Sizes for the rail-map colour stage. Coordinates assume a 640x480 map
 that fits in 10 bits. Station ids run 1 to RM_NUM_STATIONS, 0 is none.
*/
`ifndef RAIL_MAP_DEFINES_SVH
`define RAIL_MAP_DEFINES_SVH

// ----------------------------------------------------------------------
// Data widths
// ----------------------------------------------------------------------
`define RM_COORD_W        10    // Screen x or y
`define RM_CHANNEL_W      8     // One VGA colour channel
`define RM_STATION_ID_W   4     // Holds ids 0..15

// ----------------------------------------------------------------------
// Table sizes
// ----------------------------------------------------------------------
`define RM_NUM_STATIONS   12
`define RM_NUM_SEGMENTS   16    // One rectangle per route bit

// ----------------------------------------------------------------------
// Window half-widths in pixels
// ----------------------------------------------------------------------
// Marker is a 3x3 square around the station centre
`define RM_MARKER_RADIUS  1
`define RM_HOVER_RADIUS   1     // Cursor snap window

`endif

/* source/routeOverlay.sv */
/*
 Route highlighting with one inclusive rectangle per segment. Bit i of
 routeMask enables segment i. Combinational, no latency.
*/
`timescale 1ns/1ns
`include "rail_map_defines.svh"

module routeOverlay
(
    input  railMapPkg::pixelT     pixel,
    input  railMapPkg::routeMaskT routeMask,
    output logic                  routeHit
);

    // ------------------------------------------------------------------
    // Segment table, each row is xLo, xHi, yLo, yHi
    // ------------------------------------------------------------------
    localparam railMapPkg::coordT segTable [`RM_NUM_SEGMENTS][4] = '{
        '{10'd563, 10'd569, 10'd97,  10'd125},  // Stn 1 to 2
        '{10'd547, 10'd563, 10'd125, 10'd160},  // Stn 2 to 3
        '{10'd497, 10'd545, 10'd153, 10'd160},  // Stn 3 towards 4
        '{10'd465, 10'd478, 10'd188, 10'd199},  // Stn 4 to 5
        '{10'd477, 10'd479, 10'd199, 10'd219},  // Stn 5 south
        '{10'd478, 10'd489, 10'd219, 10'd229},  // Into stn 6
        '{10'd492, 10'd520, 10'd228, 10'd230},  // Stn 6 towards 7
        '{10'd491, 10'd511, 10'd231, 10'd284},  // Stn 6 south
        '{10'd501, 10'd529, 10'd285, 10'd299},  // Into stn 8
        '{10'd521, 10'd529, 10'd302, 10'd311},  // Stn 8 to 9
        '{10'd520, 10'd535, 10'd313, 10'd318},  // Stn 9 to 10
        '{10'd529, 10'd536, 10'd319, 10'd349},  // Stn 10 south
        '{10'd496, 10'd509, 10'd375, 10'd388},  // Stn 11 to 12
        '{10'd437, 10'd492, 10'd389, 10'd414},  // Stn 12 south-west
        '{10'd450, 10'd492, 10'd343, 10'd388},  // Stn 12 north-west
        '{10'd436, 10'd436, 10'd418, 10'd421}   // Single-column stub
    };

    localparam int xLo = 0;
    localparam int xHi = 1;
    localparam int yLo = 2;
    localparam int yHi = 3;

    logic [`RM_NUM_SEGMENTS-1:0] onSegment;

    // ------------------------------------------------------------------
    // Per-segment rectangle test
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `RM_NUM_SEGMENTS; i++)
    begin : gSegment
        logic insideRect;

        assign insideRect = (pixel.x >= segTable[i][xLo]) &&
                            (pixel.x <= segTable[i][xHi]) &&
                            (pixel.y >= segTable[i][yLo]) &&
                            (pixel.y <= segTable[i][yHi]);

        assign onSegment[i] = routeMask[i] && insideRect;   // Masked off segments stay land
    end

    // Any enabled segment under the pixel
    assign routeHit = |onSegment;

endmodule

/* source/stationLocator.sv */
/*
 Reports the station under the cursor, one cycle after the cursor is
 sampled. Overlapping windows resolve to the highest id.
*/
`timescale 1ns/1ns
`include "rail_map_defines.svh"

module stationLocator
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  railMapPkg::pixelT     cursor,
    output railMapPkg::stationIdT hoverStation
);

    logic [`RM_NUM_STATIONS:1] inWindow;    // Bit i set when cursor is near station i
    railMapPkg::stationIdT     hoverNext;

    // ------------------------------------------------------------------
    // Per-station window test
    // ------------------------------------------------------------------
    for (genvar i = 1; i <= `RM_NUM_STATIONS; i++)
    begin : gWindow
        railMapPkg::pixelT center;

        assign center = railMapPkg::stationCenter(railMapPkg::stationIdT'(i));

        // Signed compare so a centre near 0 does not wrap
        assign inWindow[i] =
            (int'(cursor.x) >= int'(center.x) - `RM_HOVER_RADIUS) &&
            (int'(cursor.x) <= int'(center.x) + `RM_HOVER_RADIUS) &&
            (int'(cursor.y) >= int'(center.y) - `RM_HOVER_RADIUS) &&
            (int'(cursor.y) <= int'(center.y) + `RM_HOVER_RADIUS);
    end

    // Ascending scan, so a later (higher) id overrides
    always_comb
    begin
        hoverNext = '0;
        for (int i = 1; i <= `RM_NUM_STATIONS; i++)
        begin
            if (inWindow[i])
            begin
                hoverNext = railMapPkg::stationIdT'(i);
            end
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hoverStation <= '0;
        end
        else
        begin
            hoverStation <= hoverNext;
        end
    end

endmodule
